// File: build.f
+incdir+dv
source/decode_pkg.sv
source/decode_imm.sv
source/decode_rb.sv
source/decode_rt_ra_rc.sv
source/decode_stage.sv
dv/decode_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= decode_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := sim passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/decode_model.svh
// ==============================
// Decode reference model
// Expected decoded record for one fetch bundle
// ==============================

`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

import decode_pkg::*;

// Register number with the bank bit on top; float fields get a zero pad bit
function automatic aregno_t model_reg(input fetch_bundle_t b, input logic flt,
	input int ilsb, input int flsb);
	if (flt)
		return {b.regx, 1'b0, b.instr[flsb +: FFLD_W]};
	return {b.regx, b.instr[ilsb +: FLD_W]};
endfunction

function automatic decoded_t model_decode(input fetch_bundle_t b);
	decoded_t d;
	logic [6:0] op;
	logic flt;
	imm_t limm;
	imm_t disp;
	d = '0;
	op = b.instr[6:0];
	flt = (op == OP_FLT2) || (op == OP_FLT3);
	// Long immediate is bits 38 to 19, store displacement bits 38 to 31
	limm = {{12{b.instr[38]}}, b.instr[38:19]};
	disp = {{24{b.instr[38]}}, b.instr[38:31]};
	d.opcode = opcode_e'(op);
	d.rt = model_reg(b, flt, RT_LSB, FRT_LSB);
	d.ra = model_reg(b, flt, RA_LSB, FRA_LSB);
	d.rb = model_reg(b, flt, RB_LSB, FRB_LSB);
	d.rc = model_reg(b, flt, RC_LSB, FRC_LSB);
	d.has_imm = 1'b1;
	d.imm = limm;
	case (op)
		OP_ADD, OP_SUB, OP_AND:
		begin
			d.unit = UNIT_ALU;
			d.has_imm = b.instr[39];
			d.imm = b.instr[39] ? limm : '0;
		end
		OP_ADDI, OP_ORI, OP_LDI:
			d.unit = UNIT_ALU;
		OP_LOAD:
			d.unit = UNIT_MEM;
		OP_STORE:
		begin
			d.unit = UNIT_MEM;
			d.imm = disp;
		end
		OP_BRA:
			d.unit = UNIT_BRANCH;
		OP_FLT2, OP_FLT3:
		begin
			d.unit = UNIT_FPU;
			d.has_imm = 1'b0;
			d.imm = '0;
		end
		// NOP and unknown opcodes keep only the opcode itself
		default:
		begin
			d = '0;
			d.opcode = opcode_e'(op);
			return d;
		end
	endcase
	// Zero the fields that each opcode does not read or write
	if (op == OP_STORE || op == OP_BRA)
		d.rt = '0;
	if (op == OP_LDI)
		d.ra = '0;
	if (d.has_imm || op == OP_LDI || op == OP_BRA)
		d.rb = '0;
	if (op != OP_STORE && op != OP_FLT3)
		d.rc = '0;
	return d;
endfunction

`endif

// File: dv/decode_tb.sv
// ==============================
// Decode stage testbench
// Random fetch traffic and back-pressure, scored against a model
// ==============================

`timescale 1ns/1ps

module decode_tb;

	`include "decode_model.svh"

	localparam int NUM_INSTR = 2000;
	localparam int MAX_CYCLES = NUM_INSTR * 8 + 100;

	logic clk;
	logic rst_n;
	logic in_valid;
	logic in_ready;
	logic out_valid;
	logic out_ready;
	fetch_bundle_t in_bundle;
	decoded_t out_dec;
	decoded_t exp_q[$];
	decoded_t prev_dec;
	logic prev_stall;
	logic last_taken;
	integer seed;
	int sent;
	int received;
	int cycles;
	opcode_e op_list [12] = '{OP_NOP, OP_ADD, OP_SUB, OP_AND, OP_ADDI, OP_ORI,
		OP_LDI, OP_LOAD, OP_STORE, OP_BRA, OP_FLT2, OP_FLT3};

	decode_stage dut0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_bundle (in_bundle),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_dec   (out_dec)
	);

	always #50 clk = ~clk;

	// ==============================
	// Checks
	// ==============================

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_dec(input decoded_t exp, input decoded_t act, input string name);
		if (exp != act)
		begin
			$display("FAILED %s expected %h actual %h", name, exp, act);
			fail_run("decoded record mismatch");
		end
	endtask

	task automatic check_count(input int exp, input int act, input string name);
		if (exp != act)
		begin
			$display("FAILED %s expected %h actual %h", name, exp, act);
			fail_run("transfer count mismatch");
		end
	endtask

	task automatic check_flag(input logic exp, input logic act, input string name);
		if (exp !== act)
		begin
			$display("FAILED %s expected %h actual %h", name, exp, act);
			fail_run("handshake flag mismatch");
		end
	endtask

	function automatic logic is_listed(input logic [6:0] op);
		for (int i = 0; i < 12; i++)
			if (op == op_list[i])
				return 1'b1;
		return 1'b0;
	endfunction

	// ==============================
	// Stimulus
	// ==============================

	// Called 5 ns after each rising edge
	task automatic drive_inputs();
		logic [31:0] r;
		logic [63:0] w;
		logic [6:0] op;
		r = $random(seed);
		out_ready = (r % 32'd10) < 32'd7;
		// An offered bundle stays put until the stage takes it
		if (in_valid && !last_taken)
			return;
		if (sent >= NUM_INSTR)
		begin
			in_valid = 1'b0;
			return;
		end
		r = $random(seed);
		in_valid = r[0];
		w = {$random(seed), $random(seed)};
		r = $random(seed);
		if ((r % 32'd10) != 32'd0)
			op = op_list[4'(r[15:0] % 16'd12)];
		else
		begin
			// Walk up from a random value to the next opcode with no meaning
			op = w[6:0];
			while (is_listed(op))
				op = op + 7'd1;
		end
		in_bundle.instr = {w[39:7], op};
		in_bundle.regx = w[40];
	endtask

	// Everything is sampled on the edge, before the DUT updates
	always @(posedge clk)
	begin
		if (rst_n)
		begin
			cycles++;
			if (cycles >= MAX_CYCLES)
				fail_run("timeout: not all instructions drained in time");
			if (sent == 0 && out_valid)
				fail_run("out_valid rose before any instruction was accepted");
			// A stalled output slot must block fetch, a free one must accept
			check_flag((out_valid && !out_ready) ? 1'b0 : 1'b1, in_ready, "in_ready");
			if (prev_stall && !out_valid)
				fail_run("out_valid dropped while rename was stalling");
			if (prev_stall)
				check_dec(prev_dec, out_dec, "out_dec held");
			if (out_valid && out_ready)
			begin
				if (exp_q.size() == 0)
					fail_run("output transfer with no record expected");
				check_dec(exp_q.pop_front(), out_dec, "out_dec");
				received++;
			end
			last_taken = in_valid && in_ready;
			if (last_taken)
			begin
				exp_q.push_back(model_decode(in_bundle));
				sent++;
			end
			prev_stall = out_valid && !out_ready;
			prev_dec = out_dec;
		end
	end

	initial
	begin
		seed = 16492;
		clk = 1'b0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_bundle = '0;
		out_ready = 1'b0;
		prev_stall = 1'b0;
		prev_dec = '0;
		last_taken = 1'b0;
		sent = 0;
		received = 0;
		cycles = 0;
		repeat (8) @(posedge clk);
		#5;
		if (out_valid)
			fail_run("out_valid high during reset");
		check_dec('0, out_dec, "out_dec after reset");
		rst_n = 1'b1;
		drive_inputs();
		// Run until every instruction is in and the output slot has emptied
		while (sent < NUM_INSTR || out_valid)
		begin
			@(posedge clk);
			#5;
			drive_inputs();
		end
		check_count(sent, received, "received");
		if (exp_q.size() != 0)
			fail_run("records left over in the scoreboard");
		else
		begin
			$display("sim passed");
			$finish;
		end
	end

endmodule

// File: source/decode_stage.sv
// ==============================
// Register-operand decode stage
// Decodes one fetch bundle per cycle into a record for rename,
// registered behind a valid/ready handshake
// ==============================

`timescale 1ns/1ps

module decode_stage (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	output logic in_ready,
	input decode_pkg::fetch_bundle_t in_bundle,
	output logic out_valid,
	input logic out_ready,
	output decode_pkg::decoded_t out_dec
);

	import decode_pkg::*;

	opcode_e opc;
	unit_e unit;
	logic has_imm;
	imm_t imm;
	aregno_t rt;
	aregno_t ra;
	aregno_t rb;
	aregno_t rc;
	decoded_t dec_next;

	// ==============================
	// Unit select
	// ==============================

	assign opc = get_opcode(in_bundle.instr);

	always_comb
	begin
		case (opc)
			OP_ADD, OP_SUB, OP_AND, OP_ADDI, OP_ORI, OP_LDI:
				unit = UNIT_ALU;
			OP_LOAD, OP_STORE:
				unit = UNIT_MEM;
			OP_FLT2, OP_FLT3:
				unit = UNIT_FPU;
			OP_BRA:
				unit = UNIT_BRANCH;
			// NOP and unknown opcodes are issued nowhere
			default:
				unit = UNIT_NONE;
		endcase
	end

	// ==============================
	// Field decoders
	// ==============================

	// All three look at the incoming bundle with no latency of their own
	decode_imm u_imm (
		.instr   (in_bundle.instr),
		.has_imm (has_imm),
		.imm     (imm)
	);

	// Rb alone needs to know whether an immediate replaced it
	decode_rb u_rb (
		.instr    (in_bundle.instr),
		.regx     (in_bundle.regx),
		.has_immb (has_imm),
		.rb       (rb)
	);

	decode_rt_ra_rc u_rt_ra_rc (
		.instr (in_bundle.instr),
		.regx  (in_bundle.regx),
		.rt    (rt),
		.ra    (ra),
		.rc    (rc)
	);

	// Assemble the record in the order rename expects
	always_comb
	begin
		dec_next.opcode = opc;
		dec_next.unit = unit;
		dec_next.rt = rt;
		dec_next.ra = ra;
		dec_next.rb = rb;
		dec_next.rc = rc;
		dec_next.has_imm = has_imm;
		dec_next.imm = imm;
	end

	// ==============================
	// Output register
	// ==============================

	// Room for a new record when the slot is empty or draining this edge
	assign in_ready = !out_valid || out_ready;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			out_valid <= 1'b0;
			out_dec <= '0;
		end
		else if (in_ready)
		begin
			// Slot is free: take the new record or go empty
			out_valid <= in_valid;
			if (in_valid)
				out_dec <= dec_next;
		end
		// Otherwise rename is stalling, so the record holds
	end

endmodule

// File: source/decode_rt_ra_rc.sv
// ==============================
// Rt, Ra and Rc decoder
// Target and remaining source registers with per-opcode zeroing
// ==============================

`timescale 1ns/1ps

module decode_rt_ra_rc (
	input decode_pkg::instruction_t instr,
	input logic regx,
	output decode_pkg::aregno_t rt,
	output decode_pkg::aregno_t ra,
	output decode_pkg::aregno_t rc
);

	import decode_pkg::*;

	opcode_e opc;
	logic flt;
	logic use_rt;
	logic use_ra;
	logic use_rc;

	assign opc = get_opcode(instr);
	assign flt = is_float_op(opc);

	// ==============================
	// Field usage per opcode
	// ==============================

	always_comb
	begin
		use_rt = 1'b0;
		use_ra = 1'b0;
		use_rc = 1'b0;
		case (opc)
			OP_ADD, OP_SUB, OP_AND, OP_ADDI, OP_ORI, OP_LOAD, OP_FLT2:
			begin
				use_rt = 1'b1;
				use_ra = 1'b1;
			end
			// Load immediate writes a register but reads none
			OP_LDI:
				use_rt = 1'b1;
			// Store has no target; Ra is the base and Rc holds the data
			OP_STORE:
			begin
				use_ra = 1'b1;
				use_rc = 1'b1;
			end
			// Branch compares Ra against zero and writes nothing
			OP_BRA:
				use_ra = 1'b1;
			// Three-operand float op is the only other user of Rc
			OP_FLT3:
			begin
				use_rt = 1'b1;
				use_ra = 1'b1;
				use_rc = 1'b1;
			end
			default:
			begin
				use_rt = 1'b0;
				use_ra = 1'b0;
				use_rc = 1'b0;
			end
		endcase
	end

	// ==============================
	// Register numbers
	// ==============================

	// Unused fields decode to register 0 so rename sees no false dependency
	assign rt = use_rt ? place_reg(instr, regx, flt, RT_LSB, FRT_LSB) : '0;
	assign ra = use_ra ? place_reg(instr, regx, flt, RA_LSB, FRA_LSB) : '0;
	assign rc = use_rc ? place_reg(instr, regx, flt, RC_LSB, FRC_LSB) : '0;

endmodule

// File: source/decode_rb.sv
// ==============================
// Rb decoder
// Second source register, zero when an immediate takes its place
// ==============================

`timescale 1ns/1ps

module decode_rb (
	input decode_pkg::instruction_t instr,
	input logic regx,
	input logic has_immb,
	output decode_pkg::aregno_t rb
);

	import decode_pkg::*;

	opcode_e opc;
	logic no_src_b;

	assign opc = get_opcode(instr);

	// Opcodes that never read a second source
	always_comb
	begin
		case (opc)
			OP_ADD, OP_SUB, OP_AND, OP_ADDI, OP_ORI, OP_LOAD, OP_STORE,
			OP_FLT2, OP_FLT3:
				no_src_b = 1'b0;
			// NOP, LDI, BRA and anything unknown
			default:
				no_src_b = 1'b1;
		endcase
	end

	// An immediate overlays the Rb field, so the field bits are not a register then
	always_comb
	begin
		if (has_immb || no_src_b)
			rb = '0;
		else
			rb = place_reg(instr, regx, is_float_op(opc), RB_LSB, FRB_LSB);
	end

endmodule

// File: source/decode_imm.sv
// ==============================
// Immediate decoder
// Flags the immediate forms and sign-extends their constant
// ==============================

`timescale 1ns/1ps

module decode_imm (
	input decode_pkg::instruction_t instr,
	output logic has_imm,
	output decode_pkg::imm_t imm
);

	import decode_pkg::*;

	opcode_e opc;
	logic imm_sel;
	logic [LIMM_W-1:0] limm;
	logic [DISP_W-1:0] disp;
	imm_t limm_sx;
	imm_t disp_sx;

	// ==============================
	// Raw fields
	// ==============================

	assign opc = get_opcode(instr);
	assign imm_sel = instr[IMMSEL_BIT];

	// Long immediate covers the Rb and Rc positions of the integer format
	assign limm = instr[LIMM_LSB +: LIMM_W];
	// Stores keep Rc for data, so only the top byte is left for the offset
	assign disp = instr[DISP_LSB +: DISP_W];

	// Both are signed; replicate the top bit up to 32 bits
	assign limm_sx = {{(IMM_W-LIMM_W){limm[LIMM_W-1]}}, limm};
	assign disp_sx = {{(IMM_W-DISP_W){disp[DISP_W-1]}}, disp};

	// ==============================
	// Form select
	// ==============================

	always_comb
	begin
		// Default is a register-only form with a zero constant
		has_imm = 1'b0;
		imm = '0;
		case (opc)
			OP_ADDI, OP_ORI, OP_LDI, OP_LOAD, OP_BRA:
			begin
				has_imm = 1'b1;
				imm = limm_sx;
			end
			OP_STORE:
			begin
				has_imm = 1'b1;
				imm = disp_sx;
			end
			OP_ADD, OP_SUB, OP_AND:
			begin
				// These three pick reg-reg or reg-imm by the top bit
				if (imm_sel)
				begin
					has_imm = 1'b1;
					imm = limm_sx;
				end
			end
			// NOP, float ops and unknown opcodes carry no constant
			default:
			begin
				has_imm = 1'b0;
				imm = '0;
			end
		endcase
	end

endmodule

// File: source/decode_pkg.sv
// ==============================
// Decode package
// Widths, field positions, opcode and unit encodings and the
// records passed between fetch, decode and rename
// ==============================

package decode_pkg;

	// ==============================
	// Widths
	// ==============================

	// One instruction word from fetch
	localparam int INSTR_W = 40;
	// Architectural register number, bank bit on top of a 6-bit field
	localparam int AREG_W = 7;
	// Immediate after sign extension
	localparam int IMM_W = 32;
	// Opcode sits in the low bits of every format
	localparam int OPC_LSB = 0;
	localparam int OPC_W = 7;
	// Execution unit code
	localparam int UNIT_W = 3;

	// ==============================
	// Field positions
	// ==============================

	// Integer formats use 6-bit register fields
	localparam int FLD_W = 6;
	localparam int RT_LSB = 7;
	localparam int RA_LSB = 13;
	localparam int RB_LSB = 19;
	localparam int RC_LSB = 25;

	// Long immediate overlays the Rb and Rc fields, bits 38 to 19
	localparam int LIMM_LSB = 19;
	localparam int LIMM_W = 20;
	// Store displacement lives above the store data register
	localparam int DISP_LSB = 31;
	localparam int DISP_W = 8;
	// Switches ADD, SUB and AND over to their immediate form
	localparam int IMMSEL_BIT = 39;

	// Float formats pack 5-bit register fields tighter
	localparam int FFLD_W = 5;
	localparam int FRT_LSB = 7;
	localparam int FRA_LSB = 12;
	localparam int FRB_LSB = 17;
	localparam int FRC_LSB = 22;

	// ==============================
	// Types
	// ==============================

	typedef logic [INSTR_W-1:0] instruction_t;
	typedef logic [AREG_W-1:0] aregno_t;
	typedef logic [IMM_W-1:0] imm_t;

	// Opcodes not listed here are decoded as unknown
	typedef enum logic [OPC_W-1:0] {
		OP_NOP   = 7'h00,
		OP_ADD   = 7'h02,
		OP_SUB   = 7'h03,
		OP_ADDI  = 7'h04,
		OP_AND   = 7'h08,
		OP_ORI   = 7'h0D,
		OP_LDI   = 7'h0E,
		OP_BRA   = 7'h20,
		OP_LOAD  = 7'h40,
		OP_STORE = 7'h50,
		OP_FLT2  = 7'h60,
		OP_FLT3  = 7'h61
	} opcode_e;

	typedef enum logic [UNIT_W-1:0] {
		UNIT_NONE   = 3'd0,
		UNIT_ALU    = 3'd1,
		UNIT_MEM    = 3'd2,
		UNIT_FPU    = 3'd3,
		UNIT_BRANCH = 3'd4
	} unit_e;

	// What fetch hands over each cycle
	typedef struct packed {
		instruction_t instr;
		logic regx;
	} fetch_bundle_t;

	// Decoded record handed on to rename
	typedef struct packed {
		opcode_e opcode;
		unit_e unit;
		aregno_t rt;
		aregno_t ra;
		aregno_t rb;
		aregno_t rc;
		logic has_imm;
		imm_t imm;
	} decoded_t;

	// ==============================
	// Helpers shared by the decoders
	// ==============================

	// Pull the opcode out of an instruction word
	function automatic opcode_e get_opcode(input instruction_t instr);
		return opcode_e'(instr[OPC_LSB +: OPC_W]);
	endfunction

	// True for the two float formats
	function automatic logic is_float_op(input opcode_e opc);
		return (opc == OP_FLT2) || (opc == OP_FLT3);
	endfunction

	// Build a register number from one field, bank bit on top.
	// A float field is padded with a zero bit to fill the 6 low bits
	function automatic aregno_t place_reg(
		input instruction_t instr,
		input logic regx,
		input logic is_flt,
		input int unsigned int_lsb,
		input int unsigned flt_lsb
	);
		aregno_t r;
		if (is_flt)
			r = {regx, 1'b0, instr[flt_lsb +: FFLD_W]};
		else
			r = {regx, instr[int_lsb +: FLD_W]};
		return r;
	endfunction

endpackage
